// ==== ntm_vector_params.svh ====
// NTM vector fixed-point adder shared sizes
// Word width, lane count and element-count width for every block

`ifndef NTM_VECTOR_PARAMS_SVH
`define NTM_VECTOR_PARAMS_SVH

// Data word width in bits
`define NTM_DATA_SIZE 16

// Number of scalar lanes, any value of 1 or more
`define NTM_LANES 2

// Element count width
`define NTM_SIZE_WIDTH 8

// Lane index width, never below one bit
`define NTM_LANE_WIDTH ((`NTM_LANES > 1) ? $clog2(`NTM_LANES) : 1)

`endif

// ==== ntm_fixed_pkg.sv ====
// NTM fixed-point arithmetic types
// Data word, extended sum, operation code and saturation limits

`include "ntm_vector_params.svh"

package ntm_fixed_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Words
  ////////////////////////////////////////////////////////////////////////////

  // Two's complement data word
  typedef logic signed [`NTM_DATA_SIZE-1:0] fixed_word_t;

  // One guard bit for overflow detection
  typedef logic signed [`NTM_DATA_SIZE:0] fixed_sum_t;

  // Operation bit carried by start
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } operation_e;

  // Clamp limits
  localparam fixed_word_t FIXED_MAX = {1'b0, {(`NTM_DATA_SIZE-1){1'b1}}};
  localparam fixed_word_t FIXED_MIN = {1'b1, {(`NTM_DATA_SIZE-1){1'b0}}};

endpackage

// ==== ntm_vector_ctrl_pkg.sv ====
// NTM vector sequencing types
// Lane index, element count and dispatcher state encoding

`include "ntm_vector_params.svh"

package ntm_vector_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////////////////////

  // Round-robin lane pointer
  typedef logic [`NTM_LANE_WIDTH-1:0] lane_index_t;

  // Vector length and remaining counts
  typedef logic [`NTM_SIZE_WIDTH-1:0] element_count_t;

  // Dispatcher FSM
  typedef enum logic {
    IDLE_STATE  = 1'b0,
    INPUT_STATE = 1'b1
  } dispatch_state_e;

endpackage

// ==== ntm_scalar_fixed_adder.sv ====
// NTM scalar fixed-point lane
// Saturating add or subtract, two-stage pipeline, one start per cycle

`timescale 1ns/1ps

`include "ntm_vector_params.svh"

module ntm_scalar_fixed_adder (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  ntm_fixed_pkg::operation_e operation,
  input  ntm_fixed_pkg::fixed_word_t data_a_in,
  input  ntm_fixed_pkg::fixed_word_t data_b_in,
  output logic                      ready,
  output ntm_fixed_pkg::fixed_word_t data_out
);

  // Sign-extended operands
  ntm_fixed_pkg::fixed_sum_t ext_a;
  ntm_fixed_pkg::fixed_sum_t ext_b;

  // Stage 1 registers
  ntm_fixed_pkg::fixed_sum_t op_a;
  ntm_fixed_pkg::fixed_sum_t op_b;
  logic                      valid_s1;

  // Stage 2 combinational result
  ntm_fixed_pkg::fixed_sum_t sum;
  logic                      overflow;

  assign ext_a = {data_a_in[`NTM_DATA_SIZE-1], data_a_in};
  assign ext_b = {data_b_in[`NTM_DATA_SIZE-1], data_b_in};

  // Guard bit and sign disagree on overflow
  assign sum      = op_a + op_b;
  assign overflow = sum[`NTM_DATA_SIZE] != sum[`NTM_DATA_SIZE-1];

  ////////////////////////////////////////////////////////////////////////////
  // Valid pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_s1 <= 1'b0;
      ready    <= 1'b0;
    end else begin
      valid_s1 <= start;
      ready    <= valid_s1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Stage 1, subtract turns into add of the negated B
    op_a <= ext_a;
    op_b <= (operation == ntm_fixed_pkg::OP_SUB) ? -ext_b : ext_b;

    // Stage 2, clamp by the true sign in the guard bit
    if (overflow) begin
      data_out <= sum[`NTM_DATA_SIZE] ? ntm_fixed_pkg::FIXED_MIN : ntm_fixed_pkg::FIXED_MAX;
    end else begin
      data_out <= sum[`NTM_DATA_SIZE-1:0];
    end
  end

  // Fixed two-cycle latency
  a_ready_latency : assert property (
    @(posedge CLK) disable iff (RST) start |-> ##2 ready
  ) else $error("lane ready did not follow start after two cycles");

endmodule

// ==== ntm_vector_dispatch.sv ====
// NTM vector dispatcher
// Pairs A and B elements and starts the lanes in round-robin order

`timescale 1ns/1ps

`include "ntm_vector_params.svh"

module ntm_vector_dispatch (
  input  logic                               CLK,
  input  logic                               RST,
  input  logic                               start,
  input  ntm_fixed_pkg::operation_e          operation,
  input  ntm_vector_ctrl_pkg::element_count_t size_in,
  input  logic                               data_a_in_enable,
  input  logic                               data_b_in_enable,
  input  ntm_fixed_pkg::fixed_word_t         data_a_in,
  input  ntm_fixed_pkg::fixed_word_t         data_b_in,
  output logic [`NTM_LANES-1:0]              lane_start,
  output ntm_fixed_pkg::operation_e          lane_operation,
  output ntm_fixed_pkg::fixed_word_t         lane_a,
  output ntm_fixed_pkg::fixed_word_t         lane_b
);

  // FSM and counters
  ntm_vector_ctrl_pkg::dispatch_state_e state;
  ntm_vector_ctrl_pkg::element_count_t  remaining;
  ntm_vector_ctrl_pkg::lane_index_t     lane_ptr;

  // Operand holding registers
  logic                       a_full;
  logic                       b_full;
  ntm_fixed_pkg::fixed_word_t a_reg;
  ntm_fixed_pkg::fixed_word_t b_reg;

  logic in_input;
  logic pair_fire;

  assign in_input = state == ntm_vector_ctrl_pkg::INPUT_STATE;

  // Pair completes on held or arriving operands
  assign pair_fire = in_input && (a_full || data_a_in_enable) && (b_full || data_b_in_enable);

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= ntm_vector_ctrl_pkg::IDLE_STATE;
      lane_operation <= ntm_fixed_pkg::OP_ADD;
      remaining      <= '0;
      lane_ptr       <= '0;
      a_full         <= 1'b0;
      b_full         <= 1'b0;
      lane_start     <= '0;
    end else begin
      lane_start <= '0;
      case (state)
        ntm_vector_ctrl_pkg::IDLE_STATE: begin
          if (start) begin
            // Latch per-vector setup, always begin at lane 0
            lane_operation <= operation;
            remaining      <= size_in;
            lane_ptr       <= '0;
            state          <= ntm_vector_ctrl_pkg::INPUT_STATE;
          end
        end
        ntm_vector_ctrl_pkg::INPUT_STATE: begin
          if (pair_fire) begin
            lane_start[lane_ptr] <= 1'b1;
            a_full               <= 1'b0;
            b_full               <= 1'b0;
            remaining            <= remaining - 1'b1;
            if (lane_ptr == ntm_vector_ctrl_pkg::lane_index_t'(`NTM_LANES - 1)) begin
              lane_ptr <= '0;
            end else begin
              lane_ptr <= lane_ptr + 1'b1;
            end
            // Last pair issued
            if (remaining == ntm_vector_ctrl_pkg::element_count_t'(1)) begin
              state <= ntm_vector_ctrl_pkg::IDLE_STATE;
            end
          end else begin
            if (data_a_in_enable) begin
              a_full <= 1'b1;
            end
            if (data_b_in_enable) begin
              b_full <= 1'b1;
            end
          end
        end
        default: begin
          state <= ntm_vector_ctrl_pkg::IDLE_STATE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (in_input && data_a_in_enable) begin
      a_reg <= data_a_in;
    end
    if (in_input && data_b_in_enable) begin
      b_reg <= data_b_in;
    end
    // Bypass a strobe that completes the pair
    if (pair_fire) begin
      lane_a <= a_full ? a_reg : data_a_in;
      lane_b <= b_full ? b_reg : data_b_in;
    end
  end

  // Protocol checks
  a_no_dup_a : assert property (@(posedge CLK) disable iff (RST) !(a_full && data_a_in_enable))
    else $error("second A strobe before its B");
  a_no_dup_b : assert property (@(posedge CLK) disable iff (RST) !(b_full && data_b_in_enable))
    else $error("second B strobe before its A");
  a_size_nonzero : assert property (@(posedge CLK) disable iff (RST) start |-> size_in != '0)
    else $error("vector length zero at start");
  a_start_idle : assert property (@(posedge CLK) disable iff (RST) start |-> !in_input)
    else $error("start while a vector is being dispatched");

endmodule

// ==== ntm_vector_collect.sv ====
// NTM vector collector
// Drains lane results in element order and flags the end of the vector

`timescale 1ns/1ps

`include "ntm_vector_params.svh"

module ntm_vector_collect (
  input  logic                               CLK,
  input  logic                               RST,
  input  logic                               start,
  input  ntm_vector_ctrl_pkg::element_count_t size_in,
  input  logic [`NTM_LANES-1:0]              lane_ready,
  input  ntm_fixed_pkg::fixed_word_t         lane_data [`NTM_LANES],
  output logic                               data_out_enable,
  output ntm_fixed_pkg::fixed_word_t         data_out,
  output logic                               ready
);

  // Expected lane and results still owed
  ntm_vector_ctrl_pkg::lane_index_t    expect_ptr;
  ntm_vector_ctrl_pkg::element_count_t remaining;

  logic                  hit;
  logic [`NTM_LANES-1:0] expect_mask;

  assign hit         = lane_ready[expect_ptr];
  assign expect_mask = `NTM_LANES'(1) << expect_ptr;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      expect_ptr      <= '0;
      remaining       <= '0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      data_out_enable <= hit;
      ready           <= hit && (remaining == ntm_vector_ctrl_pkg::element_count_t'(1));
      if (start) begin
        expect_ptr <= '0;
        remaining  <= size_in;
      end else if (hit) begin
        remaining <= remaining - 1'b1;
        if (expect_ptr == ntm_vector_ctrl_pkg::lane_index_t'(`NTM_LANES - 1)) begin
          expect_ptr <= '0;
        end else begin
          expect_ptr <= expect_ptr + 1'b1;
        end
      end
    end
  end

  // Output word
  always_ff @(posedge CLK) begin
    if (hit) begin
      data_out <= lane_data[expect_ptr];
    end
  end

  // Lanes must finish in issue order
  a_in_order : assert property (
    @(posedge CLK) disable iff (RST) (lane_ready & ~expect_mask) == '0
  ) else $error("lane result out of element order");
  a_one_lane : assert property (@(posedge CLK) disable iff (RST) $onehot0(lane_ready))
    else $error("more than one lane ready in a cycle");

endmodule

// ==== ntm_vector_fixed_adder.sv ====
// NTM vector fixed-point adder/subtractor
// Dispatcher, round-robin scalar lanes and in-order collector

`timescale 1ns/1ps

`include "ntm_vector_params.svh"

module ntm_vector_fixed_adder (
  input  logic                               CLK,
  input  logic                               RST,
  input  logic                               start,
  input  ntm_fixed_pkg::operation_e          operation,
  input  ntm_vector_ctrl_pkg::element_count_t size_in,
  input  logic                               data_a_in_enable,
  input  ntm_fixed_pkg::fixed_word_t         data_a_in,
  input  logic                               data_b_in_enable,
  input  ntm_fixed_pkg::fixed_word_t         data_b_in,
  output logic                               data_out_enable,
  output ntm_fixed_pkg::fixed_word_t         data_out,
  output logic                               ready
);

  // Dispatcher to lanes
  logic [`NTM_LANES-1:0]      lane_start;
  ntm_fixed_pkg::operation_e  lane_operation;
  ntm_fixed_pkg::fixed_word_t lane_a;
  ntm_fixed_pkg::fixed_word_t lane_b;

  // Lanes to collector
  logic [`NTM_LANES-1:0]      lane_ready;
  ntm_fixed_pkg::fixed_word_t lane_data [`NTM_LANES];

  ntm_vector_dispatch dispatch_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .operation       (operation),
    .size_in         (size_in),
    .data_a_in_enable(data_a_in_enable),
    .data_b_in_enable(data_b_in_enable),
    .data_a_in       (data_a_in),
    .data_b_in       (data_b_in),
    .lane_start      (lane_start),
    .lane_operation  (lane_operation),
    .lane_a          (lane_a),
    .lane_b          (lane_b)
  );

  // Scalar lanes share operands, start selects the lane
  for (genvar k = 0; k < `NTM_LANES; k++) begin : g_lane
    ntm_scalar_fixed_adder lane_i (
      .CLK      (CLK),
      .RST      (RST),
      .start    (lane_start[k]),
      .operation(lane_operation),
      .data_a_in(lane_a),
      .data_b_in(lane_b),
      .ready    (lane_ready[k]),
      .data_out (lane_data[k])
    );
  end

  ntm_vector_collect collect_i (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .size_in        (size_in),
    .lane_ready     (lane_ready),
    .lane_data      (lane_data),
    .data_out_enable(data_out_enable),
    .data_out       (data_out),
    .ready          (ready)
  );

endmodule

// ==== ntm_vector_fixed_adder_tb.sv ====
// NTM vector fixed-point adder testbench
// Directed tests with a saturating model, an output monitor and a timeout

`timescale 1ns/1ps

`include "ntm_vector_params.svh"

module ntm_vector_fixed_adder_tb;

  // Run limit in clock cycles for the whole test sequence
  localparam int TIMEOUT_CYCLES = 2000;

  logic                                CLK;
  logic                                RST;
  logic                                start;
  ntm_fixed_pkg::operation_e           operation;
  ntm_vector_ctrl_pkg::element_count_t size_in;
  logic                                data_a_in_enable;
  ntm_fixed_pkg::fixed_word_t          data_a_in;
  logic                                data_b_in_enable;
  ntm_fixed_pkg::fixed_word_t          data_b_in;
  logic                                data_out_enable;
  ntm_fixed_pkg::fixed_word_t          data_out;
  logic                                ready;

  // Expected results in element order with their last-of-vector flags
  ntm_fixed_pkg::fixed_word_t exp_words [$];
  logic                       exp_last [$];
  string                      test_name;
  int                         cycle_count;
  int unsigned                seed;

  ntm_vector_fixed_adder dut_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .operation       (operation),
    .size_in         (size_in),
    .data_a_in_enable(data_a_in_enable),
    .data_a_in       (data_a_in),
    .data_b_in_enable(data_b_in_enable),
    .data_b_in       (data_b_in),
    .data_out_enable (data_out_enable),
    .data_out        (data_out),
    .ready           (ready)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model and checks
  ////////////////////////////////////////////////////////////////////////////

  // Exact integer result clamped to the word range
  function automatic ntm_fixed_pkg::fixed_word_t saturate_result(
    ntm_fixed_pkg::operation_e op, ntm_fixed_pkg::fixed_word_t a, ntm_fixed_pkg::fixed_word_t b);
    int hi;
    int lo;
    int r;
    hi = (1 << (`NTM_DATA_SIZE - 1)) - 1;
    lo = -(1 << (`NTM_DATA_SIZE - 1));
    r  = (op == ntm_fixed_pkg::OP_SUB) ? int'(a) - int'(b) : int'(a) + int'(b);
    if (r > hi) begin
      r = hi;
    end
    if (r < lo) begin
      r = lo;
    end
    return ntm_fixed_pkg::fixed_word_t'(r);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(input string what, input ntm_fixed_pkg::fixed_word_t expected,
                            input ntm_fixed_pkg::fixed_word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch in %s (%s): expected %0d, actual %0d",
                         test_name, what, expected, actual));
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch in %s (%s): expected %b, actual %b",
                         test_name, what, expected, actual));
    end
  endtask

  task automatic expect_result(input ntm_fixed_pkg::operation_e op,
                               input ntm_fixed_pkg::fixed_word_t a,
                               input ntm_fixed_pkg::fixed_word_t b, input logic last);
    exp_words.push_back(saturate_result(op, a, b));
    exp_last.push_back(last);
  endtask

  // Each output strobe takes the next expected word and its ready flag
  always @(negedge CLK) begin
    if (!RST) begin
      if (data_out_enable === 1'b1) begin
        if (exp_words.size() == 0) begin
          fail_run($sformatf("Output strobe in %s with no result expected", test_name));
        end else begin
          check_word("data_out", exp_words.pop_front(), data_out);
          check_flag("ready", exp_last.pop_front(), ready);
        end
      end else begin
        check_flag("ready without output", 1'b0, ready);
      end
    end
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout in %s after %0d cycles", test_name, cycle_count));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge CLK);
  endtask

  task automatic start_vector(input ntm_fixed_pkg::operation_e op, input int n);
    start     = 1'b1;
    operation = op;
    size_in   = ntm_vector_ctrl_pkg::element_count_t'(n);
    @(negedge CLK);
    start = 1'b0;
  endtask

  // One-cycle strobe of A, B or both
  task automatic strobe(input logic en_a, input logic en_b,
                        input ntm_fixed_pkg::fixed_word_t a, input ntm_fixed_pkg::fixed_word_t b);
    data_a_in_enable = en_a;
    data_b_in_enable = en_b;
    data_a_in        = a;
    data_b_in        = b;
    @(negedge CLK);
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
  endtask

  task automatic wait_done();
    do @(negedge CLK); while (ready !== 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    test_name = "test_reset";
    repeat (5) begin
      @(negedge CLK);
      check_flag("ready in reset", 1'b0, ready);
      check_flag("data_out_enable in reset", 1'b0, data_out_enable);
    end
    RST = 1'b0;
    repeat (3) begin
      @(negedge CLK);
      check_flag("ready after reset", 1'b0, ready);
      check_flag("data_out_enable after reset", 1'b0, data_out_enable);
    end
  endtask

  task automatic test_single_add();
    test_name = "test_single_add";
    start_vector(ntm_fixed_pkg::OP_ADD, 1);
    expect_result(ntm_fixed_pkg::OP_ADD, 16'sd1234, -16'sd234, 1'b1);
    strobe(1'b1, 1'b1, 16'sd1234, -16'sd234);
    // Three quiet falling edges before the result
    for (int k = 1; k < 4; k++) begin
      check_flag("data_out_enable early", 1'b0, data_out_enable);
      @(negedge CLK);
    end
    check_flag("data_out_enable latency", 1'b1, data_out_enable);
    check_flag("ready with result", 1'b1, ready);
    check_word("sum", 16'sd1000, data_out);
  endtask

  task automatic test_split_arrival();
    ntm_fixed_pkg::fixed_word_t a_vals [5];
    ntm_fixed_pkg::fixed_word_t b_vals [5];
    int                         gaps [5];
    test_name = "test_split_arrival";
    a_vals = '{16'sd500, -16'sd77, 16'sd3000, 16'sd0, -16'sd1200};
    b_vals = '{16'sd20, 16'sd23, -16'sd1000, 16'sd9, -16'sd200};
    gaps   = '{3, 2, 0, 4, 1};
    start_vector(ntm_fixed_pkg::OP_SUB, 5);
    for (int i = 0; i < 5; i++) begin
      expect_result(ntm_fixed_pkg::OP_SUB, a_vals[i], b_vals[i], i == 4);
      if (gaps[i] == 0) begin
        strobe(1'b1, 1'b1, a_vals[i], b_vals[i]);
      end else if (i % 2 == 1) begin
        // B leads A here
        strobe(1'b0, 1'b1, '0, b_vals[i]);
        idle_cycles(gaps[i]);
        strobe(1'b1, 1'b0, a_vals[i], '0);
      end else begin
        strobe(1'b1, 1'b0, a_vals[i], '0);
        idle_cycles(gaps[i]);
        strobe(1'b0, 1'b1, '0, b_vals[i]);
      end
      idle_cycles(2);
    end
    wait_done();
  endtask

  task automatic test_saturation();
    ntm_fixed_pkg::fixed_word_t a_vals [5];
    ntm_fixed_pkg::fixed_word_t b_vals [5];
    test_name = "test_saturation";
    // Overflow both ways under add plus one in-range pair
    a_vals = '{ntm_fixed_pkg::FIXED_MAX, ntm_fixed_pkg::FIXED_MIN, ntm_fixed_pkg::FIXED_MAX,
               ntm_fixed_pkg::FIXED_MIN, 16'sd100};
    b_vals = '{16'sd1, -16'sd1, ntm_fixed_pkg::FIXED_MAX, ntm_fixed_pkg::FIXED_MIN, -16'sd50};
    start_vector(ntm_fixed_pkg::OP_ADD, 5);
    for (int i = 0; i < 5; i++) begin
      expect_result(ntm_fixed_pkg::OP_ADD, a_vals[i], b_vals[i], i == 4);
      strobe(1'b1, 1'b1, a_vals[i], b_vals[i]);
    end
    wait_done();
    // Subtract overflow including zero minus the most negative word
    a_vals = '{ntm_fixed_pkg::FIXED_MIN, ntm_fixed_pkg::FIXED_MAX, ntm_fixed_pkg::FIXED_MAX,
               ntm_fixed_pkg::FIXED_MIN, 16'sd0};
    b_vals = '{16'sd1, -16'sd1, ntm_fixed_pkg::FIXED_MIN, ntm_fixed_pkg::FIXED_MAX,
               ntm_fixed_pkg::FIXED_MIN};
    start_vector(ntm_fixed_pkg::OP_SUB, 5);
    for (int i = 0; i < 5; i++) begin
      expect_result(ntm_fixed_pkg::OP_SUB, a_vals[i], b_vals[i], i == 4);
      strobe(1'b1, 1'b1, a_vals[i], b_vals[i]);
    end
    wait_done();
  endtask

  task automatic test_streaming();
    ntm_fixed_pkg::operation_e  op;
    ntm_fixed_pkg::fixed_word_t a;
    ntm_fixed_pkg::fixed_word_t b;
    test_name = "test_streaming";
    op = ntm_fixed_pkg::operation_e'($urandom & 1);
    start_vector(op, 40);
    // A new pair every cycle keeps all lanes busy
    for (int i = 0; i < 40; i++) begin
      a = ntm_fixed_pkg::fixed_word_t'($urandom);
      b = ntm_fixed_pkg::fixed_word_t'($urandom);
      expect_result(op, a, b, i == 39);
      strobe(1'b1, 1'b1, a, b);
    end
    wait_done();
  endtask

  task automatic test_back_to_back();
    ntm_fixed_pkg::fixed_word_t a;
    ntm_fixed_pkg::fixed_word_t b;
    test_name = "test_back_to_back";
    start_vector(ntm_fixed_pkg::OP_ADD, 3);
    for (int i = 0; i < 3; i++) begin
      a = ntm_fixed_pkg::fixed_word_t'(10 * i);
      expect_result(ntm_fixed_pkg::OP_ADD, a, 16'sd7, i == 2);
      strobe(1'b1, 1'b1, a, 16'sd7);
    end
    wait_done();
    // Next start in the cycle right after ready
    start_vector(ntm_fixed_pkg::OP_SUB, 6);
    for (int i = 0; i < 6; i++) begin
      b = ntm_fixed_pkg::fixed_word_t'(40 * i);
      expect_result(ntm_fixed_pkg::OP_SUB, 16'sd300, b, i == 5);
      strobe(1'b1, 1'b1, 16'sd300, b);
    end
    wait_done();
  endtask

  initial begin
    seed = 32'hfe80;
    void'($urandom(seed));
    cycle_count      = 0;
    test_name        = "init";
    RST              = 1'b1;
    start            = 1'b0;
    operation        = ntm_fixed_pkg::OP_ADD;
    size_in          = '0;
    data_a_in_enable = 1'b0;
    data_a_in        = '0;
    data_b_in_enable = 1'b0;
    data_b_in        = '0;

    test_reset();
    test_single_add();
    test_split_arrival();
    test_saturation();
    test_streaming();
    test_back_to_back();
    idle_cycles(6);

    if (exp_words.size() != 0) begin
      fail_run($sformatf("%0d results never appeared at the output", exp_words.size()));
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== ntm_vector_fixed_adder.f ====
+incdir+.
ntm_fixed_pkg.sv
ntm_vector_ctrl_pkg.sv
ntm_scalar_fixed_adder.sv
ntm_vector_dispatch.sv
ntm_vector_collect.sv
ntm_vector_fixed_adder.sv
ntm_vector_fixed_adder_tb.sv
